// ==== verilog/fifo_pkg.sv ====
`default_nettype none

package fifo_pkg;

    // write side is one wide word, read side one narrow slice
    localparam int WR_WIDTH = 64;
    localparam int RD_WIDTH = 16;
    localparam int RD_RATIO = WR_WIDTH / RD_WIDTH;

    // capacity in words and in slices
    localparam int WR_DEPTH = 16;
    localparam int RD_DEPTH = WR_DEPTH * RD_RATIO;

    // address widths
    localparam int WR_AW = $clog2(WR_DEPTH);
    localparam int RD_AW = $clog2(RD_DEPTH);

    // bits of the read pointer that pick the slice inside a word
    localparam int IDX_W = $clog2(RD_RATIO);

    typedef logic [WR_WIDTH-1:0] wr_word_t;
    typedef logic [RD_WIDTH-1:0] rd_word_t;

    // one extra top bit on each pointer tells full from empty
    typedef logic [WR_AW:0] wr_ptr_t;
    typedef logic [RD_AW:0] rd_ptr_t;

    typedef logic [IDX_W-1:0] slice_idx_t;

    // wide enough to hold the full depth
    typedef logic [WR_AW:0] wr_cnt_t;
    typedef logic [RD_AW:0] rd_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/fifo_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo_ram (
    input  logic                       sys_clk,
    input  logic                       we,
    input  logic [fifo_pkg::WR_AW-1:0] waddr,
    input  fifo_pkg::wr_word_t         wdata,
    input  logic                       re,
    input  logic [fifo_pkg::WR_AW-1:0] raddr,
    output fifo_pkg::wr_word_t         rdata
);

    fifo_pkg::wr_word_t mem [0:fifo_pkg::WR_DEPTH-1];

    // write port
    always_ff @(posedge sys_clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, output register keeps its word between reads
    always_ff @(posedge sys_clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fifo_pointers.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo_pointers (
    input  logic              sys_clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  logic              rd_en,
    output fifo_pkg::wr_ptr_t wr_ptr,
    output fifo_pkg::rd_ptr_t rd_ptr,
    output logic              ram_we,
    output logic              ram_re,
    output logic              full,
    output logic              empty
);

    // read pointer counted in words, same width as the write pointer
    fifo_pkg::wr_ptr_t rd_word;

    assign rd_word = rd_ptr[fifo_pkg::RD_AW:fifo_pkg::IDX_W];

    // a word stays stored until its last slice has gone
    assign empty = (rd_word == wr_ptr);

    // same address, opposite lap
    assign full = (wr_ptr[fifo_pkg::WR_AW] != rd_word[fifo_pkg::WR_AW]) &&
                  (wr_ptr[fifo_pkg::WR_AW-1:0] == rd_word[fifo_pkg::WR_AW-1:0]);

    // accepted strobes, ignored requests change nothing
    assign ram_we = wr_en & ~full;
    assign ram_re = rd_en & ~empty;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (ram_we) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // one step per slice, carries into the word part after the last one
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (ram_re) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fifo_occupancy.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo_occupancy (
    input  fifo_pkg::wr_ptr_t wr_ptr,
    input  fifo_pkg::rd_ptr_t rd_ptr,
    output fifo_pkg::wr_cnt_t wr_data_count,
    output fifo_pkg::wr_cnt_t wr_data_space,
    output fifo_pkg::rd_cnt_t rd_data_count,
    output fifo_pkg::rd_cnt_t rd_data_space
);

    fifo_pkg::wr_ptr_t rd_word;
    fifo_pkg::rd_ptr_t wr_slice;

    assign rd_word = rd_ptr[fifo_pkg::RD_AW:fifo_pkg::IDX_W];

    // write pointer scaled to slices, RD_RATIO is a power of two
    assign wr_slice = {wr_ptr, {fifo_pkg::IDX_W{1'b0}}};

    // modular differences, the extra pointer bit covers the full case
    assign wr_data_count = fifo_pkg::wr_cnt_t'(wr_ptr - rd_word);
    assign rd_data_count = fifo_pkg::rd_cnt_t'(wr_slice - rd_ptr);

    // partly read words count as used on the write side
    assign wr_data_space = fifo_pkg::wr_cnt_t'(fifo_pkg::WR_DEPTH) - wr_data_count;
    assign rd_data_space = fifo_pkg::rd_cnt_t'(fifo_pkg::RD_DEPTH) - rd_data_count;

endmodule

`default_nettype wire

// ==== verilog/slice_unpack.sv ====
`timescale 1ns/10ps
`default_nettype none

module slice_unpack (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  logic                 re,
    input  fifo_pkg::slice_idx_t slice_idx,
    input  fifo_pkg::wr_word_t   word,
    output logic                 valid,
    output fifo_pkg::rd_word_t   dout
);

    // read issued last cycle, its word is on the RAM output now
    logic                 re_q;
    fifo_pkg::slice_idx_t idx_q;
    fifo_pkg::rd_word_t   slice_sel;

    // index 0 is the most significant slice
    assign slice_sel =
        word[(fifo_pkg::RD_RATIO - 1 - int'(idx_q)) * fifo_pkg::RD_WIDTH +: fifo_pkg::RD_WIDTH];

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            re_q  <= 1'b0;
            idx_q <= '0;
        end else begin
            re_q <= re;
            if (re) begin
                idx_q <= slice_idx;
            end
        end
    end

    // one valid pulse per accepted read, dout holds otherwise
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            dout  <= '0;
        end else begin
            valid <= re_q;
            if (re_q) begin
                dout <= slice_sel;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fifo_wide_narrow.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo_wide_narrow (
    input  logic               sys_clk,
    input  logic               sys_rst,
    input  logic               wr_en,
    input  fifo_pkg::wr_word_t din,
    input  logic               rd_en,
    output logic               valid,
    output fifo_pkg::rd_word_t dout,
    output logic               full,
    output logic               empty,
    output fifo_pkg::wr_cnt_t  wr_data_count,
    output fifo_pkg::wr_cnt_t  wr_data_space,
    output fifo_pkg::rd_cnt_t  rd_data_count,
    output fifo_pkg::rd_cnt_t  rd_data_space
);

    logic               rst_meta;
    logic               rst_n;

    fifo_pkg::wr_ptr_t  wr_ptr;
    fifo_pkg::rd_ptr_t  rd_ptr;
    logic               ram_we;
    logic               ram_re;
    fifo_pkg::wr_word_t ram_rdata;

    // reset goes low at once, comes back two edges after sys_rst rises
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            rst_meta <= 1'b0;
            rst_n    <= 1'b0;
        end else begin
            rst_meta <= 1'b1;
            rst_n    <= rst_meta;
        end
    end

    fifo_pointers u_pointers (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_ptr  (wr_ptr),
        .rd_ptr  (rd_ptr),
        .ram_we  (ram_we),
        .ram_re  (ram_re),
        .full    (full),
        .empty   (empty)
    );

    fifo_occupancy u_occupancy (
        .wr_ptr        (wr_ptr),
        .rd_ptr        (rd_ptr),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count),
        .rd_data_space (rd_data_space)
    );

    // word address drops the wrap bit, read address also drops the slice index
    fifo_ram u_ram (
        .sys_clk (sys_clk),
        .we      (ram_we),
        .waddr   (wr_ptr[fifo_pkg::WR_AW-1:0]),
        .wdata   (din),
        .re      (ram_re),
        .raddr   (rd_ptr[fifo_pkg::RD_AW-1:fifo_pkg::IDX_W]),
        .rdata   (ram_rdata)
    );

    slice_unpack u_unpack (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .re        (ram_re),
        .slice_idx (rd_ptr[fifo_pkg::IDX_W-1:0]),
        .word      (ram_rdata),
        .valid     (valid),
        .dout      (dout)
    );

endmodule

`default_nettype wire

// ==== tests/fifo_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo_props (
    input logic              sys_clk,
    input logic              rst_n,
    input logic              rd_en,
    input logic              full,
    input logic              empty,
    input logic              valid,
    input fifo_pkg::wr_cnt_t wr_data_count
);

    int   assert_errors = 0;
    logic rd_accept;

    assign rd_accept = rd_en && !empty;

    // flags follow the word count, which is never zero and at depth at once
    a_full_empty: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (full == (wr_data_count == fifo_pkg::WR_DEPTH)) &&
        (empty == (wr_data_count == 0)))
        else begin
            assert_errors++;
            $error("full or empty disagrees with wr_data_count");
        end

    // valid shows one cycle after the accepting edge
    a_valid_after_read: assert property (@(posedge sys_clk) disable iff (!rst_n)
        rd_accept |-> ##2 valid)
        else begin
            assert_errors++;
            $error("accepted read gave no valid pulse");
        end

    a_valid_needs_read: assert property (@(posedge sys_clk) disable iff (!rst_n)
        valid |-> $past(rd_accept, 2))
        else begin
            assert_errors++;
            $error("valid without an accepted read");
        end

    a_count_bound: assert property (@(posedge sys_clk) disable iff (!rst_n)
        wr_data_count <= fifo_pkg::WR_DEPTH)
        else begin
            assert_errors++;
            $error("wr_data_count above depth");
        end

endmodule

bind fifo_wide_narrow fifo_props u_props (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .rd_en         (rd_en),
    .full          (full),
    .empty         (empty),
    .valid         (valid),
    .wr_data_count (wr_data_count)
);

`default_nettype wire

// ==== tests/tb_fifo_wide_narrow.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fifo_wide_narrow;

    localparam int CLK_PERIOD = 10;
    localparam int RANDOM_CYCLES = 400;
    // reset, single word, fill, drain, underflow, random traffic, flushes
    localparam int TEST_CYCLES = 11 + 8 + fifo_pkg::WR_DEPTH + 2 + fifo_pkg::RD_DEPTH + 8
                                 + RANDOM_CYCLES + 4;
    localparam int TIMEOUT_NS = TEST_CYCLES * CLK_PERIOD + 1000;

    logic               sys_clk;
    logic               sys_rst;
    logic               wr_en;
    fifo_pkg::wr_word_t din;
    logic               rd_en;
    logic               valid;
    fifo_pkg::rd_word_t dout;
    logic               full;
    logic               empty;
    fifo_pkg::wr_cnt_t  wr_data_count;
    fifo_pkg::wr_cnt_t  wr_data_space;
    fifo_pkg::rd_cnt_t  rd_data_count;
    fifo_pkg::rd_cnt_t  rd_data_space;

    // reference model, slices in read order
    fifo_pkg::rd_word_t slice_q[$];
    int                 model_words;
    int                 model_slices;
    // read accepted at the last edge, shows up after the next one
    logic               pend_valid;
    fifo_pkg::rd_word_t pend_data;
    logic               exp_valid;
    fifo_pkg::rd_word_t exp_dout;

    int                 errors;
    int                 checks;
    string              test_name;
    logic [31:0]        rng_state;

    fifo_wide_narrow uut (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .wr_en         (wr_en),
        .din           (din),
        .rd_en         (rd_en),
        .valid         (valid),
        .dout          (dout),
        .full          (full),
        .empty         (empty),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count),
        .rd_data_space (rd_data_space)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // flags and levels follow from the stored words and slices
    task automatic check_outputs();
        compare("full", model_words == fifo_pkg::WR_DEPTH, full);
        compare("empty", model_words == 0, empty);
        compare("wr_data_count", model_words, wr_data_count);
        compare("wr_data_space", fifo_pkg::WR_DEPTH - model_words, wr_data_space);
        compare("rd_data_count", model_slices, rd_data_count);
        compare("rd_data_space", fifo_pkg::RD_DEPTH - model_slices, rd_data_space);
        compare("valid", exp_valid, valid);
        compare("dout", exp_dout, dout);
    endtask

    // one clock cycle, called 1 ns after a rising edge
    task automatic cycle(input logic w, input logic r, input fifo_pkg::wr_word_t d);
        logic acc_w;
        logic acc_r;
        acc_w = w && (model_words < fifo_pkg::WR_DEPTH);
        acc_r = r && (model_words > 0);
        wr_en = w;
        rd_en = r;
        din   = d;
        @(posedge sys_clk);
        exp_valid = pend_valid;
        if (pend_valid) begin
            exp_dout = pend_data;
        end
        pend_valid = acc_r;
        if (acc_r) begin
            pend_data = slice_q.pop_front();
            model_slices--;
            // last slice of a word frees the word
            if (model_slices % fifo_pkg::RD_RATIO == 0) begin
                model_words--;
            end
        end
        if (acc_w) begin
            // most significant slice leaves first
            for (int i = fifo_pkg::RD_RATIO - 1; i >= 0; i--) begin
                slice_q.push_back(d[i * fifo_pkg::RD_WIDTH +: fifo_pkg::RD_WIDTH]);
            end
            model_words++;
            model_slices += fifo_pkg::RD_RATIO;
        end
        #1;
        check_outputs();
    endtask

    task automatic apply_reset();
        sys_rst = 1'b0;
        wr_en   = 1'b0;
        rd_en   = 1'b0;
        din     = '0;
        repeat (8) @(posedge sys_clk);
        #1;
        sys_rst = 1'b1;
        // synchronizer needs two edges
        repeat (2) @(posedge sys_clk);
        #1;
    endtask

    task automatic test_after_reset();
        test_name = "after_reset";
        check_outputs();
    endtask

    task automatic test_single_word();
        test_name = "single_word";
        cycle(1'b1, 1'b0, 64'h1111_2222_3333_4444);
        repeat (fifo_pkg::RD_RATIO) cycle(1'b0, 1'b1, '0);
        compare("empty after last slice", 1'b1, empty);
        repeat (2) cycle(1'b0, 1'b0, '0);
    endtask

    task automatic test_fill();
        fifo_pkg::wr_word_t word;
        test_name = "fill";
        for (int i = 0; i < fifo_pkg::WR_DEPTH; i++) begin
            word = {4{16'(16'hA000 + i)}} ^ {16'h0, 16'h0100, 16'h0200, 16'h0300};
            cycle(1'b1, 1'b0, word);
        end
        compare("full after fill", 1'b1, full);
        compare("wr_data_count after fill", fifo_pkg::WR_DEPTH, wr_data_count);
        // refused write, must never come back out
        cycle(1'b1, 1'b0, 64'hDEAD_BEEF_DEAD_BEEF);
        compare("wr_data_count after extra write", fifo_pkg::WR_DEPTH, wr_data_count);
        wr_en = 1'b0;
    endtask

    task automatic test_drain_underflow();
        fifo_pkg::rd_word_t last;
        test_name = "drain_underflow";
        while (model_words > 0) begin
            cycle(1'b0, 1'b1, '0);
        end
        repeat (2) cycle(1'b0, 1'b0, '0);
        last = exp_dout;
        repeat (5) begin
            cycle(1'b0, 1'b1, '0);
            compare("valid while empty", 1'b0, valid);
            compare("dout hold while empty", last, dout);
            compare("rd_data_count while empty", 0, rd_data_count);
        end
        rd_en = 1'b0;
    endtask

    task automatic test_random_traffic();
        logic [31:0]        rnd;
        logic               w;
        logic               r;
        fifo_pkg::wr_word_t word;
        test_name = "random_traffic";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rnd = next_rand();
            w = (rnd[1:0] == 2'b00);
            // alternate between filling and draining phases
            if ((n / 100) % 2 == 0) begin
                r = rnd[2];
            end else begin
                r = (rnd[5:3] != 3'b000);
            end
            word[63:32] = next_rand();
            word[31:0]  = next_rand();
            cycle(w, r, word);
        end
        repeat (2) cycle(1'b0, 1'b0, '0);
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        rng_state    = 32'h6441;
        model_words  = 0;
        model_slices = 0;
        pend_valid   = 1'b0;
        pend_data    = '0;
        exp_valid    = 1'b0;
        exp_dout     = '0;
        test_name    = "reset";

        apply_reset();
        test_after_reset();
        test_single_word();
        test_fill();
        test_drain_underflow();
        test_random_traffic();

        $display("checks: %0d, errors: %0d, assertion errors: %0d",
                 checks, errors, uut.u_props.assert_errors);
        if (errors == 0 && uut.u_props.assert_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/fifo_pkg.sv
verilog/fifo_ram.sv
verilog/fifo_pointers.sv
verilog/fifo_occupancy.sv
verilog/slice_unpack.sv
verilog/fifo_wide_narrow.sv
tests/fifo_props.sv
tests/tb_fifo_wide_narrow.sv

// ==== Bender.yml ====
package:
  name: fifo_wide_narrow

sources:
  # design, package first
  - files:
      - verilog/fifo_pkg.sv
      - verilog/fifo_ram.sv
      - verilog/fifo_pointers.sv
      - verilog/fifo_occupancy.sv
      - verilog/slice_unpack.sv
      - verilog/fifo_wide_narrow.sv

  # simulation only
  - target: test
    files:
      - tests/fifo_props.sv
      - tests/tb_fifo_wide_narrow.sv
